//--- flist.f
+incdir+source
source/arch_defs_pkg.sv
source/pipe_types_pkg.sv
source/credit_fifo.sv
source/alu_stage.sv
source/status_logic_unit.sv
source/result_port.sv
source/exec_pipe.sv
test/tb_exec_pipe.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_exec_pipe
FLIST     = flist.f
PASS_MSG  = All tests passed!

SRCS = $(filter-out +%,$(shell cat $(FLIST))) $(wildcard source/*.svh)
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- test/tb_exec_pipe.sv
`timescale 1ns/10ps

`include "arch_macros.svh"

module tb_exec_pipe;

    import arch_defs_pkg::*;
    import pipe_types_pkg::*;

    logic         clk;
    logic         rst_n;
    logic         op_valid;
    exec_op_t     op;
    logic         op_credit;
    logic         res_valid;
    exec_result_t res;
    logic         res_credit;

    // Issuer side owned by the main sequence
    exec_op_t               pending[$];
    exec_result_t           exp_q[$];
    int                     credits;
    logic [`DATA_WIDTH-1:0] model_status;
    logic [31:0]            stim_state;

    // Sink side
    int          owed;
    int          delay;
    logic        hold_credits;
    logic [31:0] sink_state;

    // Bookkeeping
    exec_result_t exp_res;
    int           res_count;
    int           cmp_errors;
    int           tb_errors;
    int           res_at_start;
    int           errs_at_start;
    int           tests_run;
    int           tests_failed;

    exec_pipe u_exec_pipe (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_valid   (op_valid),
        .op         (op),
        .op_credit  (op_credit),
        .res_valid  (res_valid),
        .res        (res),
        .res_credit (res_credit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = xorshift(stim_state);
        return stim_state;
    endfunction

    function automatic exec_op_t make_op(input opcode_t oc, input logic [7:0] a,
                                         input logic [7:0] b);
        exec_op_t o;
        o.opcode    = oc;
        o.operand_a = a;
        o.operand_b = b;
        return o;
    endfunction

    function automatic exec_op_t rand_op();
        logic [31:0] r;
        r = next_rand();
        // 15 defined opcodes from 0 through 14
        return make_op(opcode_t'(4'(r % 32'd15)), r[15:8], r[23:16]);
    endfunction

    // Expected result and status after one operation
    function automatic exec_result_t model_op(input exec_op_t o,
                                              input logic [`DATA_WIDTH-1:0] st);
        logic [`DATA_WIDTH:0]   sum;
        logic [`DATA_WIDTH-1:0] v;
        logic                   c;
        logic                   z;
        logic                   n;
        exec_result_t           r;
        c = st[`STATUS_CPU_CARRY];
        z = st[`STATUS_CPU_ZERO];
        n = st[`STATUS_CPU_NEG];
        v = '0;
        case (o.opcode)
            ADD: begin
                sum = {1'b0, o.operand_a} + {1'b0, o.operand_b};
                v   = sum[`DATA_WIDTH-1:0];
                c   = sum[`DATA_WIDTH];
            end
            SUB: begin
                v = o.operand_a - o.operand_b;
                // Borrow
                c = (o.operand_a < o.operand_b);
            end
            AND: begin
                v = o.operand_a & o.operand_b;
                c = 1'b0;
            end
            OR: begin
                v = o.operand_a | o.operand_b;
                c = 1'b0;
            end
            XOR: begin
                v = o.operand_a ^ o.operand_b;
                c = 1'b0;
            end
            INR: v = o.operand_a + 8'd1;
            DCR: v = o.operand_a - 8'd1;
            LDI_A, LDI_B, LDI_C, LDA, PLA: v = o.operand_b;
            SEC: c = 1'b1;
            CLC: c = 1'b0;
            default: ;
        endcase
        // Z and N follow the value except for NOP and carry control
        if (!(o.opcode inside {NOP, SEC, CLC})) begin
            z = (v == '0);
            n = v[`DATA_WIDTH-1];
        end
        r.opcode                  = o.opcode;
        r.value                   = v;
        r.status                  = '0;
        r.status[`STATUS_CPU_CARRY] = c;
        r.status[`STATUS_CPU_ZERO]  = z;
        r.status[`STATUS_CPU_NEG]   = n;
        return r;
    endfunction

    // One issuer cycle collects a returned credit and then pushes if allowed
    task automatic step();
        exec_op_t     o;
        exec_result_t e;
        @(negedge clk);
        if (op_credit) begin
            credits++;
        end
        // Returned credits never exceed what the input buffer holds
        assert (credits <= `OP_FIFO_DEPTH) else begin
            $display("op_credit returned more credits than the input buffer holds");
            tb_errors++;
        end
        if (credits > 0 && pending.size() > 0) begin
            o            = pending.pop_front();
            e            = model_op(o, model_status);
            model_status = e.status;
            exp_q.push_back(e);
            op       = o;
            op_valid = 1'b1;
            credits--;
        end else begin
            op_valid = 1'b0;
        end
        // Callers see queues and counters after compare and sink have run
        #1;
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (pending.size() > 0 || exp_q.size() > 0 || owed > 0) begin
            step();
            cycles++;
            if (cycles > limit) begin
                $display("Timeout after %0d cycles waiting for results to drain", limit);
                $display("Test failures found");
                $finish;
            end
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = cmp_errors + tb_errors - errs_at_start;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("%-14s %0d results, %0d errors", name, res_count - res_at_start, errs);
        errs_at_start = cmp_errors + tb_errors;
        res_at_start  = res_count;
    endtask

    // Compare each result against the oldest expected entry
    always @(negedge clk) begin
        if (rst_n && res_valid) begin
            res_count++;
            assert (exp_q.size() > 0) else begin
                $display("Result arrived with no operation outstanding");
                cmp_errors++;
            end
            if (exp_q.size() > 0) begin
                exp_res = exp_q.pop_front();
                assert (res.opcode === exp_res.opcode) else begin
                    $display("[ERROR] res.opcode got 0x%h expected 0x%h",
                             res.opcode, exp_res.opcode);
                    cmp_errors++;
                end
                assert (res.value === exp_res.value) else begin
                    $display("[ERROR] res.value got 0x%h expected 0x%h",
                             res.value, exp_res.value);
                    cmp_errors++;
                end
                assert (res.status === exp_res.status) else begin
                    $display("[ERROR] res.status got 0x%h expected 0x%h",
                             res.status, exp_res.status);
                    cmp_errors++;
                end
            end
        end
    end

    // Sink returns one credit per result after a random delay
    initial begin
        res_credit = 1'b0;
        owed       = 0;
        delay      = 0;
        sink_state = 32'd73;
        forever begin
            @(negedge clk);
            res_credit = 1'b0;
            if (rst_n) begin
                if (res_valid) begin
                    owed++;
                end
                if (owed > 0 && !hold_credits) begin
                    if (delay == 0) begin
                        res_credit = 1'b1;
                        owed--;
                        sink_state = xorshift(sink_state);
                        delay      = int'(sink_state % 32'd4);
                    end else begin
                        delay--;
                    end
                end
            end
        end
    end

    initial begin
        opcode_t     loads[5];
        logic [7:0]  load_vals[5];
        logic [31:0] r;
        int          got;
        loads         = '{LDI_A, LDI_B, LDI_C, LDA, PLA};
        load_vals     = '{8'h00, 8'h80, 8'h7f, 8'hff, 8'h01};
        rst_n         = 1'b0;
        op_valid      = 1'b0;
        op            = '0;
        hold_credits  = 1'b0;
        credits       = `OP_FIFO_DEPTH;
        model_status  = '0;
        stim_state    = 32'd73;
        res_count     = 0;
        cmp_errors    = 0;
        tb_errors     = 0;
        res_at_start  = 0;
        errs_at_start = 0;
        tests_run     = 0;
        tests_failed  = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Carry out and borrow corners first
        pending.push_back(make_op(ADD, 8'hff, 8'h01));
        pending.push_back(make_op(SUB, 8'h00, 8'h01));
        pending.push_back(make_op(SUB, 8'h05, 8'h05));
        for (int i = 0; i < 20; i++) begin
            r = next_rand();
            pending.push_back(make_op(r[0] ? SUB : ADD, r[15:8], r[23:16]));
        end
        wait_drain(500);
        end_test("arithmetic");

        // ADD sets C and INR and DCR wrap and keep it until logic clears it
        pending.push_back(make_op(ADD, 8'h80, 8'h80));
        pending.push_back(make_op(INR, 8'hff, 8'h00));
        pending.push_back(make_op(DCR, 8'h00, 8'h00));
        r = next_rand();
        pending.push_back(make_op(AND, r[7:0], r[15:8]));
        pending.push_back(make_op(ADD, 8'hff, 8'h02));
        pending.push_back(make_op(OR, r[15:8], r[23:16]));
        pending.push_back(make_op(INR, 8'h7f, 8'h00));
        pending.push_back(make_op(XOR, r[23:16], r[23:16]));
        wait_drain(500);
        end_test("logic_inr_dcr");

        // Every load with C set and then with C clear
        pending.push_back(make_op(SEC, 8'h00, 8'h00));
        for (int i = 0; i < 5; i++) begin
            pending.push_back(make_op(loads[i], 8'h00, load_vals[i]));
        end
        pending.push_back(make_op(CLC, 8'h00, 8'h00));
        for (int i = 0; i < 5; i++) begin
            pending.push_back(make_op(loads[i], 8'h00, load_vals[4 - i]));
        end
        wait_drain(500);
        end_test("loads");

        // NOP with junk operands must still keep everything
        pending.push_back(make_op(ADD, 8'hff, 8'h01));
        pending.push_back(make_op(NOP, 8'h12, 8'h34));
        pending.push_back(make_op(CLC, 8'h80, 8'h80));
        pending.push_back(make_op(NOP, 8'hff, 8'hff));
        pending.push_back(make_op(SEC, 8'h01, 8'h01));
        pending.push_back(make_op(LDA, 8'h00, 8'h90));
        pending.push_back(make_op(NOP, 8'h00, 8'h00));
        pending.push_back(make_op(CLC, 8'h00, 8'h00));
        wait_drain(500);
        end_test("carry_nop");

        // Withhold downstream credits and watch the pipe fill up
        hold_credits = 1'b1;
        for (int i = 0; i < 12; i++) begin
            pending.push_back(rand_op());
        end
        for (int i = 0; i < 40; i++) begin
            step();
        end
        got = res_count - res_at_start;
        assert (got <= `RES_CREDITS) else begin
            $display("[ERROR] res_valid pulses got 0x%h expected at most 0x%h",
                     got, `RES_CREDITS);
            tb_errors++;
        end
        assert (credits == 0 && pending.size() > 0) else begin
            $display("Issuer did not stall after spending its credits");
            tb_errors++;
        end
        hold_credits = 1'b0;
        wait_drain(1000);
        end_test("backpressure");

        for (int i = 0; i < 300; i++) begin
            pending.push_back(rand_op());
        end
        wait_drain(5000);
        end_test("random_mix");

        $display("Tests run %0d, failed %0d, results %0d, errors %0d",
                 tests_run, tests_failed, res_count, cmp_errors + tb_errors);
        if (cmp_errors + tb_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- source/exec_pipe.sv
`timescale 1ns/10ps

module exec_pipe (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         op_valid,
    input  pipe_types_pkg::exec_op_t     op,
    output logic                         op_credit,
    output logic                         res_valid,
    output pipe_types_pkg::exec_result_t res,
    input  logic                         res_credit
);

    import pipe_types_pkg::*;

    // Buffer to ALU stage
    logic         fifo_valid;
    exec_op_t     fifo_data;
    logic         alu_ready;

    // ALU stage to status logic
    logic         alu_valid;
    alu_result_t  alu_data;
    logic         slu_ready;

    // Status logic to result port
    logic         slu_valid;
    exec_result_t slu_data;
    logic         port_ready;

    // Input buffer pops whenever the ALU stage can take an entry
    credit_fifo u_credit_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (op_valid),
        .push_data (op),
        .pop       (alu_ready),
        .pop_valid (fifo_valid),
        .pop_data  (fifo_data),
        .credit    (op_credit)
    );

    alu_stage u_alu_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fifo_valid),
        .in_op     (fifo_data),
        .in_ready  (alu_ready),
        .out_valid (alu_valid),
        .out       (alu_data),
        .out_ready (slu_ready)
    );

    status_logic_unit u_status_logic_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (alu_valid),
        .in        (alu_data),
        .in_ready  (slu_ready),
        .out_valid (slu_valid),
        .out       (slu_data),
        .out_ready (port_ready)
    );

    result_port u_result_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (slu_valid),
        .in         (slu_data),
        .in_ready   (port_ready),
        .res_valid  (res_valid),
        .res        (res),
        .res_credit (res_credit)
    );

endmodule

//--- source/result_port.sv
`timescale 1ns/10ps

`include "arch_macros.svh"

module result_port (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  pipe_types_pkg::exec_result_t in,
    output logic                         in_ready,
    output logic                         res_valid,
    output pipe_types_pkg::exec_result_t res,
    input  logic                         res_credit
);

    import pipe_types_pkg::*;

    localparam int cnt_w = $clog2(`RES_CREDITS + 1);
    localparam logic [cnt_w-1:0] init_credits = cnt_w'(`RES_CREDITS);

    // Output slot
    exec_result_t slot;
    logic         slot_valid;

    // Downstream credits still available
    logic [cnt_w-1:0] credit_cnt;
    logic             send;

    // Slot goes out whenever a credit is held
    assign send      = slot_valid && (credit_cnt != '0);
    assign res_valid = send;
    assign res       = slot;

    // Accept when the slot is empty or leaving now
    assign in_ready = !slot_valid || send;

    // Slot occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
        end else if (in_ready) begin
            slot_valid <= in_valid;
        end
    end

    // Slot payload
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            slot <= in;
        end
    end

    // Credit counter
    // Send and return in one cycle cancel out
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= init_credits;
        end else begin
            unique case ({send, res_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

//--- source/status_logic_unit.sv
`timescale 1ns/10ps

`include "arch_macros.svh"

module status_logic_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  pipe_types_pkg::alu_result_t  in,
    output logic                         in_ready,
    output logic                         out_valid,
    output pipe_types_pkg::exec_result_t out,
    input  logic                         out_ready
);

    import arch_defs_pkg::*;
    import pipe_types_pkg::*;

    // Architectural status register
    logic [`DATA_WIDTH-1:0] status_q;
    logic [`DATA_WIDTH-1:0] status_next;

    logic zero_next;
    logic neg_next;
    logic carry_next;
    logic advance;

    assign in_ready = !out_valid || out_ready;
    assign advance  = in_valid && in_ready;

    // Flag selection, starting from the current status
    always_comb begin
        zero_next  = status_q[`STATUS_CPU_ZERO];
        neg_next   = status_q[`STATUS_CPU_NEG];
        carry_next = status_q[`STATUS_CPU_CARRY];

        if (in.load_sets_zn) begin
            // Loads take Z and N from the loaded value, C kept
            zero_next = (in.value == '0);
            neg_next  = in.value[`DATA_WIDTH-1];
        end else begin
            unique case (in.alu_op)
                // Increment and decrement leave carry alone
                ALU_INR, ALU_DCR: begin
                    zero_next = in.alu_zero;
                    neg_next  = in.alu_negative;
                end
                // NOP, SEC and CLC keep all flags here
                ALU_NOP: ;
                default: begin
                    zero_next  = in.alu_zero;
                    neg_next   = in.alu_negative;
                    carry_next = in.alu_carry;
                end
            endcase
        end

        // Explicit carry control wins over everything above
        if (in.set_carry) begin
            carry_next = 1'b1;
        end else if (in.clear_carry) begin
            carry_next = 1'b0;
        end
    end

    // Pack flags into the status byte, unused bits zero
    always_comb begin
        status_next                    = '0;
        status_next[`STATUS_CPU_CARRY] = carry_next;
        status_next[`STATUS_CPU_ZERO]  = zero_next;
        status_next[`STATUS_CPU_NEG]   = neg_next;
    end

    // Status register and stage valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_q  <= '0;
            out_valid <= 1'b0;
        end else begin
            if (advance) begin
                status_q <= status_next;
            end
            if (in_ready) begin
                out_valid <= in_valid;
            end
        end
    end

    // Result carries the status after this operation
    always_ff @(posedge clk) begin
        if (advance) begin
            out.opcode <= in.opcode;
            out.value  <= in.value;
            out.status <= status_next;
        end
    end

endmodule

//--- source/alu_stage.sv
`timescale 1ns/10ps

`include "arch_macros.svh"

module alu_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  pipe_types_pkg::exec_op_t    in_op,
    output logic                        in_ready,
    output logic                        out_valid,
    output pipe_types_pkg::alu_result_t out,
    input  logic                        out_ready
);

    import arch_defs_pkg::*;
    import pipe_types_pkg::*;

    // Constant one at ALU width plus carry
    localparam logic [`DATA_WIDTH:0] wide_one = {{`DATA_WIDTH{1'b0}}, 1'b1};

    alu_op_t                alu_op;
    logic                   load_sets_zn;
    logic                   set_carry;
    logic                   clear_carry;
    logic [`DATA_WIDTH:0]   wide;
    logic [`DATA_WIDTH:0]   a_ext;
    logic [`DATA_WIDTH:0]   b_ext;
    logic [`DATA_WIDTH-1:0] value;
    logic                   load_en;

    // Register moves when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;
    assign load_en  = in_valid && in_ready;

    // Opcode decode into ALU control bits
    always_comb begin
        alu_op       = ALU_NOP;
        load_sets_zn = 1'b0;
        set_carry    = 1'b0;
        clear_carry  = 1'b0;
        unique case (in_op.opcode)
            ADD: alu_op = ALU_ADD;
            SUB: alu_op = ALU_SUB;
            AND: alu_op = ALU_AND;
            OR:  alu_op = ALU_OR;
            XOR: alu_op = ALU_XOR;
            INR: alu_op = ALU_INR;
            DCR: alu_op = ALU_DCR;
            // All loads pass operand b and set Z and N
            LDI_A, LDI_B, LDI_C, LDA, PLA: begin
                alu_op       = ALU_PASS;
                load_sets_zn = 1'b1;
            end
            SEC: set_carry   = 1'b1;
            CLC: clear_carry = 1'b1;
            default: ;
        endcase
    end

    // Operands extended by one bit to catch carry and borrow
    assign a_ext = {1'b0, in_op.operand_a};
    assign b_ext = {1'b0, in_op.operand_b};

    // Datapath
    // Top bit of wide is the carry out, or the borrow for SUB
    always_comb begin
        unique case (alu_op)
            ALU_ADD:  wide = a_ext + b_ext;
            ALU_SUB:  wide = a_ext - b_ext;
            ALU_AND:  wide = a_ext & b_ext;
            ALU_OR:   wide = a_ext | b_ext;
            ALU_XOR:  wide = a_ext ^ b_ext;
            ALU_INR:  wide = a_ext + wide_one;
            ALU_DCR:  wide = a_ext - wide_one;
            ALU_PASS: wide = b_ext;
            default:  wide = '0;
        endcase
    end

    assign value = wide[`DATA_WIDTH-1:0];

    // Stage valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload with raw flags and controls
    always_ff @(posedge clk) begin
        if (load_en) begin
            out.opcode       <= in_op.opcode;
            out.value        <= value;
            out.alu_zero     <= (value == '0);
            out.alu_carry    <= wide[`DATA_WIDTH];
            out.alu_negative <= value[`DATA_WIDTH-1];
            out.alu_op       <= alu_op;
            out.load_sets_zn <= load_sets_zn;
            out.set_carry    <= set_carry;
            out.clear_carry  <= clear_carry;
        end
    end

endmodule

//--- source/credit_fifo.sv
`timescale 1ns/10ps

`include "arch_macros.svh"

module credit_fifo (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     push,
    input  pipe_types_pkg::exec_op_t push_data,
    input  logic                     pop,
    output logic                     pop_valid,
    output pipe_types_pkg::exec_op_t pop_data,
    output logic                     credit
);

    import pipe_types_pkg::*;

    localparam int ptr_w = $clog2(`OP_FIFO_DEPTH);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(`OP_FIFO_DEPTH - 1);

    // Storage array
    exec_op_t mem [`OP_FIFO_DEPTH];

    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w:0]   count;
    logic             do_pop;

    // Head entry is always on the output
    assign pop_valid = (count != '0);
    assign pop_data  = mem[rd_ptr];

    // Real pop only with a valid head
    assign do_pop = pop && pop_valid;

    // One credit back per entry released
    assign credit = do_pop;

    // Write side
    // Issuer only pushes with a credit, so there is always room
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count unchanged
            if (push && !do_pop) begin
                count <= count + 1'b1;
            end else if (!push && do_pop) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- source/pipe_types_pkg.sv
`include "arch_macros.svh"

package pipe_types_pkg;

    // Decoded operation as pushed by the issuer
    // operand_b also carries immediate and bus load data
    typedef struct packed {
        arch_defs_pkg::opcode_t  opcode;
        logic [`DATA_WIDTH-1:0]  operand_a;
        logic [`DATA_WIDTH-1:0]  operand_b;
    } exec_op_t;

    // ALU stage output with raw flags and decoded controls
    typedef struct packed {
        arch_defs_pkg::opcode_t  opcode;
        logic [`DATA_WIDTH-1:0]  value;
        logic                    alu_zero;
        logic                    alu_carry;
        logic                    alu_negative;
        arch_defs_pkg::alu_op_t  alu_op;
        logic                    load_sets_zn;
        logic                    set_carry;
        logic                    clear_carry;
    } alu_result_t;

    // Finished result with the status after the operation
    typedef struct packed {
        arch_defs_pkg::opcode_t  opcode;
        logic [`DATA_WIDTH-1:0]  value;
        logic [`DATA_WIDTH-1:0]  status;
    } exec_result_t;

endpackage

//--- source/arch_defs_pkg.sv
package arch_defs_pkg;

    // Opcodes as seen by the execute back end
    typedef enum logic [3:0] {
        NOP   = 4'h0,
        // Two-operand arithmetic
        ADD   = 4'h1,
        SUB   = 4'h2,
        // Bitwise logic
        AND   = 4'h3,
        OR    = 4'h4,
        XOR   = 4'h5,
        // Increment and decrement of operand a
        INR   = 4'h6,
        DCR   = 4'h7,
        // Immediate loads into A, B and C
        LDI_A = 4'h8,
        LDI_B = 4'h9,
        LDI_C = 4'ha,
        // Loads from the internal bus
        LDA   = 4'hb,
        PLA   = 4'hc,
        // Explicit carry control
        SEC   = 4'hd,
        CLC   = 4'he
    } opcode_t;

    // Operation selected inside the ALU
    typedef enum logic [3:0] {
        ALU_NOP  = 4'h0,
        ALU_ADD  = 4'h1,
        ALU_SUB  = 4'h2,
        ALU_AND  = 4'h3,
        ALU_OR   = 4'h4,
        ALU_XOR  = 4'h5,
        ALU_INR  = 4'h6,
        ALU_DCR  = 4'h7,
        // Passes operand b through for loads
        ALU_PASS = 4'h8
    } alu_op_t;

endpackage

//--- source/arch_macros.svh
`ifndef ARCH_MACROS_SVH
`define ARCH_MACROS_SVH

// Operand and result width
`define DATA_WIDTH 8

// Bit positions in the status byte
// Remaining bits always read as zero
`define STATUS_CPU_CARRY 0
`define STATUS_CPU_ZERO  1
`define STATUS_CPU_NEG   2

// Entries in the input operation buffer
// Issuer starts out holding this many credits
`define OP_FIFO_DEPTH 4

// Credits held by the result port after reset
`define RES_CREDITS 2

`endif
